/* logic/cla_adder.sv */
// Carry-lookahead adder with zero carry in, used by the Vedic multiplier tree
`timescale 1ns/10ps

module cla_adder #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] sum,
    output logic             carry
);

    logic [WIDTH-1:0] prop;
    logic [WIDTH-1:0] gen;
    logic [WIDTH:0]   c;

    assign prop = a ^ b;
    assign gen  = a & b;

    // Each carry as a flat sum of generate terms and propagate chains
    always_comb begin
        logic chain;
        c = '0;
        for (int i = 0; i < WIDTH; i++) begin
            for (int j = 0; j <= i; j++) begin
                chain = gen[j];
                for (int k = j + 1; k <= i; k++) begin
                    chain = chain & prop[k];
                end
                c[i+1] = c[i+1] | chain;
            end
        end
    end

    assign sum   = prop ^ c[WIDTH-1:0];
    assign carry = c[WIDTH];

endmodule

/* logic/product_sign.sv */
// Product and output stages, restoring the sign of the Vedic product
`timescale 1ns/10ps

module product_sign
    import vmul_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  mag_stage_t stage,
    input  product_t   raw_product,
    output product_t   p,
    output logic       out_valid
);

    localparam int SIGNED_MAX = (MAX_MAGNITUDE + 1) / 2;
    localparam int NEG_LIMIT  = SIGNED_MAX * SIGNED_MAX;

    product_t raw_q;
    logic     valid_q;
    logic     negate_q;
    product_t signed_p;

    // Stage 3, raw product
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raw_q    <= '0;
            valid_q  <= 1'b0;
            negate_q <= 1'b0;
        end else begin
            raw_q    <= raw_product;
            valid_q  <= stage.valid;
            negate_q <= stage.negate;
        end
    end

    assign signed_p = negate_q ? product_t'(-raw_q) : raw_q;

    // Stage 4, result
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            p         <= '0;
            out_valid <= 1'b0;
        end else begin
            p         <= signed_p;
            out_valid <= valid_q;
        end
    end

    // A negative result only comes from signed magnitudes
    a_neg_range: assert property (@(posedge clk) disable iff (rst)
        negate_q |-> raw_q <= NEG_LIMIT);

endmodule

/* logic/sign_magnitude.sv */
// Input and magnitude stages, turning operands into magnitudes plus a negate flag
`timescale 1ns/10ps

module sign_magnitude
    import vmul_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  operand_u   a,
    input  operand_u   b,
    input  logic       signed_mode,
    output mag_stage_t stage
);

    // Largest magnitude of a two's complement operand
    localparam int SIGNED_MAX = (MAX_MAGNITUDE + 1) / 2;

    operand_u a_q;
    operand_u b_q;
    logic     valid_q;
    logic     mode_q;
    logic     neg_a;
    logic     neg_b;
    operand_t mag_a;
    operand_t mag_b;

    // Stage 1, raw inputs
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_q     <= '0;
            b_q     <= '0;
            valid_q <= 1'b0;
            mode_q  <= 1'b0;
        end else begin
            a_q     <= a;
            b_q     <= b;
            valid_q <= in_valid;
            mode_q  <= signed_mode;
        end
    end

    assign neg_a = mode_q && (a_q.s < 0);
    assign neg_b = mode_q && (b_q.s < 0);
    assign mag_a = neg_a ? operand_t'(-a_q.s) : a_q.u;
    assign mag_b = neg_b ? operand_t'(-b_q.s) : b_q.u;

    // Stage 2, magnitudes and the sign of the final product
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage <= '0;
        end else begin
            stage <= '{valid: valid_q, mag_a: mag_a, mag_b: mag_b, negate: neg_a ^ neg_b};
        end
    end

    // -128 is the only operand whose magnitude reaches the limit
    a_signed_mag: assert property (@(posedge clk) disable iff (rst)
        (stage.valid && $past(mode_q)) |-> (stage.mag_a <= SIGNED_MAX && stage.mag_b <= SIGNED_MAX));

endmodule

/* logic/vedic_mult.sv */
// Recursive unsigned Vedic multiplier, purely combinational, built from 2-bit cells
`timescale 1ns/10ps

module vedic_mult #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]   a,
    input  logic [WIDTH-1:0]   b,
    output logic [2*WIDTH-1:0] p
);

    localparam int HALF = WIDTH / 2;

    generate
        if (WIDTH == 2) begin : g_cell
            logic cross_lo;
            logic cross_hi;
            logic top;
            logic mid_carry;

            assign cross_lo  = a[0] & b[1];
            assign cross_hi  = a[1] & b[0];
            assign top       = a[1] & b[1];
            assign mid_carry = cross_lo & cross_hi;

            // Two half adders on the partial products
            assign p = {top & mid_carry, top ^ mid_carry, cross_lo ^ cross_hi, a[0] & b[0]};
        end else begin : g_tree
            logic [WIDTH-1:0] ll;
            logic [WIDTH-1:0] lh;
            logic [WIDTH-1:0] hl;
            logic [WIDTH-1:0] hh;
            logic [WIDTH-1:0] mid_sum;
            logic [WIDTH-1:0] upper;
            logic [WIDTH-1:0] high;
            logic             mid_carry;
            logic             upper_carry;

            vedic_mult #(.WIDTH(HALF)) u_ll (.a(a[HALF-1:0]), .b(b[HALF-1:0]), .p(ll));
            vedic_mult #(.WIDTH(HALF)) u_lh (.a(a[HALF-1:0]), .b(b[WIDTH-1:HALF]), .p(lh));
            vedic_mult #(.WIDTH(HALF)) u_hl (.a(a[WIDTH-1:HALF]), .b(b[HALF-1:0]), .p(hl));
            vedic_mult #(.WIDTH(HALF)) u_hh (.a(a[WIDTH-1:HALF]), .b(b[WIDTH-1:HALF]), .p(hh));

            // Cross terms
            cla_adder #(.WIDTH(WIDTH)) u_add_mid (
                .a     (lh),
                .b     (hl),
                .sum   (mid_sum),
                .carry (mid_carry)
            );

            // Fold in the upper half of the low product
            cla_adder #(.WIDTH(WIDTH)) u_add_upper (
                .a     (mid_sum),
                .b     ({{HALF{1'b0}}, ll[WIDTH-1:HALF]}),
                .sum   (upper),
                .carry (upper_carry)
            );

            // Either carry lands one bit above the spilled half
            cla_adder #(.WIDTH(WIDTH)) u_add_high (
                .a     (hh),
                .b     ({{(HALF-1){1'b0}}, mid_carry | upper_carry, upper[WIDTH-1:HALF]}),
                .sum   (high),
                .carry ()
            );

            assign p = {high, upper[HALF-1:0], ll[HALF-1:0]};
        end
    endgenerate

endmodule

/* logic/vmul_pkg.sv */
// Shared widths, limits and stage types for the pipelined Vedic multiplier
package vmul_pkg;

    localparam int OPERAND_W = 8;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // Rising edges from input sampling to p
    localparam int PIPE_LATENCY = 4;

    // Largest magnitude an unsigned operand can take
    localparam int MAX_MAGNITUDE = (1 << OPERAND_W) - 1;

    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [PRODUCT_W-1:0] product_t;

    // Same operand bits, read per signed_mode
    typedef union packed {
        operand_t                    u;
        logic signed [OPERAND_W-1:0] s;
    } operand_u;

    // Word between the magnitude stage and the product stages
    typedef struct packed {
        logic     valid;
        operand_t mag_a;
        operand_t mag_b;
        logic     negate;
    } mag_stage_t;

endpackage

/* logic/vmul_top.sv */
// Top level of the 4-stage signed/unsigned Vedic multiplier
`timescale 1ns/10ps

module vmul_top
    import vmul_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  operand_u a,
    input  operand_u b,
    input  logic     signed_mode,
    output product_t p,
    output logic     out_valid
);

    mag_stage_t stage;
    product_t   raw_product;

    sign_magnitude u_sign_magnitude (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .a           (a),
        .b           (b),
        .signed_mode (signed_mode),
        .stage       (stage)
    );

    // Between stage 2 and stage 3
    vedic_mult #(
        .WIDTH (OPERAND_W)
    ) u_vedic_mult (
        .a (stage.mag_a),
        .b (stage.mag_b),
        .p (raw_product)
    );

    product_sign u_product_sign (
        .clk         (clk),
        .rst         (rst),
        .stage       (stage),
        .raw_product (raw_product),
        .p           (p),
        .out_valid   (out_valid)
    );

endmodule

/* project.f */
logic/vmul_pkg.sv
logic/cla_adder.sv
logic/vedic_mult.sv
logic/sign_magnitude.sv
logic/product_sign.sv
logic/vmul_top.sv
tests/vmul_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the Vedic multiplier testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=vmul_sim

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module vmul_tb -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
fi

if grep -q -x "Finished with no errors" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* tests/vmul_tb.sv */
// Random self-checking testbench for vmul_top, comparing every product with a behavioral model
`timescale 1ns/10ps

module vmul_tb
    import vmul_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_PAIRS = 40;
    localparam int STREAM_PAIRS = 60;
    localparam int DRAIN_LIMIT  = 20;

    // One pending result and the edge count at which it must show up
    typedef struct packed {
        product_t expected;
        int       due_edge;
    } pending_t;

    logic     clk;
    logic     rst;
    logic     in_valid;
    operand_u a;
    operand_u b;
    logic     signed_mode;
    product_t p;
    logic     out_valid;

    integer   seed;
    int       edge_count;
    pending_t expect_q[$];
    operand_t corners[5] = '{8'd0, 8'd1, 8'd127, 8'd128, 8'd255};

    vmul_top uut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .a           (a),
        .b           (b),
        .signed_mode (signed_mode),
        .p           (p),
        .out_valid   (out_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_product(product_t actual, product_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: p = 0x%04h, expected 0x%04h", $time, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_valid(logic actual, logic expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: out_valid = %b, expected %b", $time, actual, expected);
            abort_run();
        end
    endtask

    // Plain product of both operands, read as signed or unsigned, cut to the product width
    function automatic product_t model_product(operand_t x, operand_t y, logic mode);
        int xv;
        int yv;
        if (mode) begin
            xv = int'($signed(x));
            yv = int'($signed(y));
        end else begin
            xv = int'(x);
            yv = int'(y);
        end
        return product_t'(xv * yv);
    endfunction

    task automatic apply_pair(operand_t x, operand_t y, logic mode);
        pending_t entry;
        @(posedge clk);
        in_valid    <= 1'b1;
        a.u         <= x;
        b.u         <= y;
        signed_mode <= mode;
        entry.expected = model_product(x, y, mode);
        // edge_count still holds the count before this edge
        // The next edge samples the pair and is the first edge of the latency
        entry.due_edge = edge_count + 1 + PIPE_LATENCY;
        expect_q.push_back(entry);
    endtask

    // Garbage data in a slot without a strobe
    task automatic idle_cycle();
        @(posedge clk);
        in_valid    <= 1'b0;
        a.u         <= operand_t'($random(seed));
        b.u         <= operand_t'($random(seed));
        signed_mode <= 1'($random(seed));
    endtask

    // Each falling edge either owes the front result or must show no strobe
    always @(negedge clk) begin
        logic     due;
        pending_t entry;
        due = (expect_q.size() != 0) && (expect_q[0].due_edge == edge_count);
        check_valid(out_valid, due);
        if (due) begin
            entry = expect_q.pop_front();
            check_product(p, entry.expected);
        end
    end

    initial begin
        operand_t x;
        operand_t y;
        int       wait_count;

        clk         = 1'b0;
        rst         = 1'b1;
        in_valid    = 1'b0;
        a           = '0;
        b           = '0;
        signed_mode = 1'b0;
        seed        = 48;
        edge_count  = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_valid(out_valid, 1'b0);
        check_product(p, '0);

        // Unsigned pairs with occasional gaps
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            x = operand_t'($random(seed));
            y = operand_t'($random(seed));
            apply_pair(x, y, 1'b0);
            if (($random(seed) & 3) == 0) begin
                idle_cycle();
            end
        end

        // Signed pairs, cycling through the sign combinations
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            x = operand_t'($random(seed));
            y = operand_t'($random(seed));
            case (i % 4)
                0: begin
                    x[OPERAND_W-1] = 1'b1;
                    y[OPERAND_W-1] = 1'b1;
                end
                1: begin
                    x[OPERAND_W-1] = 1'b1;
                    y[OPERAND_W-1] = 1'b0;
                end
                2: begin
                    x[OPERAND_W-1] = 1'b0;
                    y[OPERAND_W-1] = 1'b1;
                end
                default: ;
            endcase
            apply_pair(x, y, 1'b1);
            if (($random(seed) & 3) == 0) begin
                idle_cycle();
            end
        end

        // Every corner pair in both modes
        for (int m = 0; m < 2; m++) begin
            foreach (corners[i]) begin
                foreach (corners[j]) begin
                    apply_pair(corners[i], corners[j], 1'(m));
                end
            end
            idle_cycle();
        end

        // Full pipeline, mode free to change on every pair
        for (int i = 0; i < STREAM_PAIRS; i++) begin
            x = operand_t'($random(seed));
            y = operand_t'($random(seed));
            apply_pair(x, y, 1'($random(seed)));
        end
        repeat (6) idle_cycle();

        wait_count = 0;
        while (expect_q.size() != 0 && wait_count < DRAIN_LIMIT) begin
            @(posedge clk);
            wait_count++;
        end
        if (expect_q.size() != 0) begin
            $display("Timeout: %0d results never arrived on out_valid", expect_q.size());
            abort_run();
        end else begin
            // Quiet cycles, out_valid must stay low
            repeat (4) @(posedge clk);
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule
